/* Makefile */
SRCS := $(wildcard hw/*.sv verif/*.sv)

.PHONY: all run clean

all: run

obj_dir/Vmini_core_tb: $(SRCS) mini_core.f
	verilator --binary --timing --assert --top-module mini_core_tb \
		-f mini_core.f -o Vmini_core_tb

run: obj_dir/Vmini_core_tb
	./obj_dir/Vmini_core_tb | tee /dev/stderr | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

/* hw/core_ex_stage.sv */
////////////////////////////////////////
// ALU and EX/WB register
// Single-cycle ALU, no shifter
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module core_ex_stage (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  core_pkg::id_ex_pipe_t id_ex_pipe_i,
  output logic                  ex_ready_o,
  input  logic                  wb_ready_i,
  output core_pkg::rf_wr_t      ex_fwd_o,
  output core_pkg::ex_wb_pipe_t ex_wb_pipe_o
);

  logic [core_pkg::XLEN-1:0] a;
  logic [core_pkg::XLEN-1:0] b;
  logic [core_pkg::XLEN-1:0] alu_result;
  core_pkg::ex_wb_pipe_t     ex_wb_q;

  assign a = id_ex_pipe_i.operand_a;
  assign b = id_ex_pipe_i.operand_b;

  // ALU, stores use the add for the address
  always_comb begin
    case (id_ex_pipe_i.alu_op)
      core_pkg::ALU_SUB:    alu_result = a - b;
      core_pkg::ALU_AND:    alu_result = a & b;
      core_pkg::ALU_OR:     alu_result = a | b;
      core_pkg::ALU_XOR:    alu_result = a ^ b;
      core_pkg::ALU_SLT:    alu_result = {31'd0, $signed(a) < $signed(b)};
      core_pkg::ALU_PASS_B: alu_result = b;
      default:              alu_result = a + b;
    endcase
  end

  // Forward candidate for the item now in ID
  assign ex_fwd_o.we    = id_ex_pipe_i.valid && id_ex_pipe_i.rf_we;
  assign ex_fwd_o.waddr = id_ex_pipe_i.rd;
  assign ex_fwd_o.wdata = alu_result;

  assign ex_ready_o = !ex_wb_q.valid || wb_ready_i;

  // EX/WB register
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ex_wb_q.valid <= 1'b0;
    end else if (ex_ready_o) begin
      ex_wb_q.valid <= id_ex_pipe_i.valid;
    end
    if (id_ex_pipe_i.valid && ex_ready_o) begin
      ex_wb_q.rd         <= id_ex_pipe_i.rd;
      ex_wb_q.rf_we      <= id_ex_pipe_i.rf_we;
      ex_wb_q.result     <= alu_result;
      ex_wb_q.store_en   <= id_ex_pipe_i.store_en;
      ex_wb_q.store_data <= id_ex_pipe_i.store_data;
    end
  end

  assign ex_wb_pipe_o = ex_wb_q;

endmodule

`default_nettype wire

/* hw/core_id_stage.sv */
////////////////////////////////////////
// Decode, operand read and forwarding
// Shifts, SLTIU, SLTU and non-word stores decode as illegal
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module core_id_stage (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  core_pkg::if_id_pipe_t if_id_pipe_i,
  output logic                  id_ready_o,
  input  logic                  ex_ready_i,
  input  core_pkg::rf_wr_t      ex_fwd_i,
  input  core_pkg::rf_wr_t      wb_wr_i,
  output core_pkg::id_ex_pipe_t id_ex_pipe_o
);

  logic [31:0]                     instr;
  core_pkg::opcode_e               opcode;
  logic [2:0]                      funct3;
  logic [6:0]                      funct7;
  logic [core_pkg::REG_ADDR_W-1:0] rs1;
  logic [core_pkg::REG_ADDR_W-1:0] rs2;
  logic [core_pkg::XLEN-1:0]       imm_i;
  logic [core_pkg::XLEN-1:0]       imm_s;
  logic [core_pkg::XLEN-1:0]       imm_u;
  logic [core_pkg::XLEN-1:0]       imm;
  logic [core_pkg::XLEN-1:0]       rf_rdata_a;
  logic [core_pkg::XLEN-1:0]       rf_rdata_b;
  logic [core_pkg::XLEN-1:0]       rs1_val;
  logic [core_pkg::XLEN-1:0]       rs2_val;
  core_pkg::alu_op_e               alu_op;
  logic                            use_imm;
  logic                            rf_we;
  logic                            store_en;
  logic                            illegal;
  core_pkg::id_ex_pipe_t           id_ex_q;

  // Forward mux, EX first, then WB, then register file
  function automatic logic [core_pkg::XLEN-1:0] fwd_operand(
    input logic [core_pkg::REG_ADDR_W-1:0] rs,
    input logic [core_pkg::XLEN-1:0]       rf_data,
    input core_pkg::rf_wr_t                ex_fwd,
    input core_pkg::rf_wr_t                wb_wr
  );
    logic [core_pkg::XLEN-1:0] value;
    value = rf_data;
    // x0 never forwarded
    if (rs != '0) begin
      if (ex_fwd.we && (ex_fwd.waddr == rs)) begin
        value = ex_fwd.wdata;
      end else if (wb_wr.we && (wb_wr.waddr == rs)) begin
        value = wb_wr.wdata;
      end
    end
    return value;
  endfunction

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////

  assign instr  = if_id_pipe_i.instr;
  assign opcode = core_pkg::opcode_e'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rs1    = instr[19:15];
  assign rs2    = instr[24:20];

  // Sign-extended immediates
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u = {instr[31:12], 12'h000};

  core_register_file register_file_i (
    .clk_i     ( clk_i      ),
    .reset_i   ( reset_i    ),
    .raddr_a_i ( rs1        ),
    .raddr_b_i ( rs2        ),
    .rdata_a_o ( rf_rdata_a ),
    .rdata_b_o ( rf_rdata_b ),
    .wr_i      ( wb_wr_i    )
  );

  assign rs1_val = fwd_operand(rs1, rf_rdata_a, ex_fwd_i, wb_wr_i);
  assign rs2_val = fwd_operand(rs2, rf_rdata_b, ex_fwd_i, wb_wr_i);

  ////////////////////////////////////////
  // Decoder
  ////////////////////////////////////////

  always_comb begin
    alu_op   = core_pkg::ALU_ADD;
    imm      = imm_i;
    use_imm  = 1'b1;
    rf_we    = 1'b0;
    store_en = 1'b0;
    illegal  = 1'b0;
    case (opcode)
      core_pkg::OPC_OP_IMM: begin
        rf_we = 1'b1;
        case (funct3)
          3'b000:  alu_op = core_pkg::ALU_ADD;
          3'b010:  alu_op = core_pkg::ALU_SLT;
          3'b100:  alu_op = core_pkg::ALU_XOR;
          3'b110:  alu_op = core_pkg::ALU_OR;
          3'b111:  alu_op = core_pkg::ALU_AND;
          default: illegal = 1'b1;
        endcase
      end
      core_pkg::OPC_OP: begin
        rf_we   = 1'b1;
        use_imm = 1'b0;
        case ({funct7, funct3})
          {7'b0000000, 3'b000}: alu_op = core_pkg::ALU_ADD;
          {7'b0100000, 3'b000}: alu_op = core_pkg::ALU_SUB;
          {7'b0000000, 3'b010}: alu_op = core_pkg::ALU_SLT;
          {7'b0000000, 3'b100}: alu_op = core_pkg::ALU_XOR;
          {7'b0000000, 3'b110}: alu_op = core_pkg::ALU_OR;
          {7'b0000000, 3'b111}: alu_op = core_pkg::ALU_AND;
          default:              illegal = 1'b1;
        endcase
      end
      core_pkg::OPC_LUI: begin
        rf_we  = 1'b1;
        alu_op = core_pkg::ALU_PASS_B;
        imm    = imm_u;
      end
      core_pkg::OPC_STORE: begin
        // SW only, address is rs1 + S immediate
        store_en = 1'b1;
        imm      = imm_s;
        illegal  = (funct3 != 3'b010);
      end
      default: illegal = 1'b1;
    endcase
    // Illegal words retire with no effect
    if (illegal) begin
      rf_we    = 1'b0;
      store_en = 1'b0;
    end
  end

  ////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////

  assign id_ready_o = !id_ex_q.valid || ex_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      id_ex_q.valid <= 1'b0;
    end else if (id_ready_o) begin
      id_ex_q.valid <= if_id_pipe_i.valid;
    end
    // Payload
    if (if_id_pipe_i.valid && id_ready_o) begin
      id_ex_q.alu_op     <= alu_op;
      id_ex_q.operand_a  <= rs1_val;
      id_ex_q.operand_b  <= use_imm ? imm : rs2_val;
      id_ex_q.rd         <= instr[11:7];
      id_ex_q.rf_we      <= rf_we;
      id_ex_q.store_en   <= store_en;
      id_ex_q.store_data <= rs2_val;
    end
  end

  assign id_ex_pipe_o = id_ex_q;

endmodule

`default_nettype wire

/* hw/core_if_stage.sv */
////////////////////////////////////////
// One outstanding fetch, PC steps by four only
// fetch_enable_i is sticky until reset
// boot_addr_i must hold still once fetch is enabled
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module core_if_stage (
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      fetch_enable_i,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,
  output logic                      instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [31:0]               instr_rdata_i,
  input  logic                      id_ready_i,
  output core_pkg::if_id_pipe_t     if_id_pipe_o
);

  logic                      fetch_en_q;
  logic                      outstanding_q;
  logic [core_pkg::XLEN-1:0] pc_q;
  logic [core_pkg::XLEN-1:0] rsp_pc_q;
  core_pkg::if_id_pipe_t     if_id_q;
  logic                      slot_free;
  logic                      req_gnt;
  logic                      rsp_take;

  ////////////////////////////////////////
  // Bus request
  ////////////////////////////////////////

  // IF/ID empty or being drained this cycle
  assign slot_free = !if_id_q.valid || id_ready_i;

  // Once raised the request stays up, IF/ID cannot refill while idle
  assign instr_req_o  = fetch_en_q && !outstanding_q && slot_free;
  assign instr_addr_o = pc_q;
  assign req_gnt      = instr_req_o && instr_gnt_i;
  assign rsp_take     = instr_rvalid_i && outstanding_q;

  // Fetch enable latch
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      fetch_en_q <= 1'b0;
    end else if (fetch_enable_i) begin
      fetch_en_q <= 1'b1;
    end
  end

  // PC follows boot address until fetch starts
  always_ff @(posedge clk_i) begin
    if (reset_i || !fetch_en_q) begin
      pc_q <= boot_addr_i;
    end else if (req_gnt) begin
      pc_q <= pc_q + core_pkg::PC_STEP;
    end
  end

  // Outstanding flag, set at grant, cleared by the response
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= 1'b0;
    end else if (req_gnt) begin
      outstanding_q <= 1'b1;
    end else if (rsp_take) begin
      outstanding_q <= 1'b0;
    end
  end

  // Tag for the word in flight
  always_ff @(posedge clk_i) begin
    if (req_gnt) begin
      rsp_pc_q <= pc_q;
    end
  end

  ////////////////////////////////////////
  // IF/ID register
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      if_id_q.valid <= 1'b0;
    end else if (rsp_take) begin
      if_id_q.valid <= 1'b1;
    end else if (id_ready_i) begin
      if_id_q.valid <= 1'b0;
    end
    // Payload
    if (rsp_take) begin
      if_id_q.pc    <= rsp_pc_q;
      if_id_q.instr <= instr_rdata_i;
    end
  end

  assign if_id_pipe_o = if_id_q;

endmodule

`default_nettype wire

/* hw/core_pkg.sv */
////////////////////////////////////////
// Widths, encodings and pipeline records for the mini RV32I core
// Only OP-IMM, OP, LUI and SW decode as legal
////////////////////////////////////////
`default_nettype none

package core_pkg;

  // Datapath and register file sizes
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int NUM_REGS   = 32;
  // Sequential fetch only, no branches
  localparam int PC_STEP    = 4;

  // Major opcodes kept from RV32I
  typedef enum logic [6:0] {
    OPC_OP_IMM = 7'b0010011,
    OPC_STORE  = 7'b0100011,
    OPC_OP     = 7'b0110011,
    OPC_LUI    = 7'b0110111
  } opcode_e;

  // ALU operations
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6
  } alu_op_e;

  // IF/ID register
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
  } if_id_pipe_t;

  // ID/EX register, operands already forwarded
  typedef struct packed {
    logic                  valid;
    alu_op_e               alu_op;
    logic [XLEN-1:0]       operand_a;
    logic [XLEN-1:0]       operand_b;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_we;
    logic                  store_en;
    logic [XLEN-1:0]       store_data;
  } id_ex_pipe_t;

  // EX/WB register
  // Store address travels in result
  typedef struct packed {
    logic                  valid;
    logic [REG_ADDR_W-1:0] rd;
    logic                  rf_we;
    logic [XLEN-1:0]       result;
    logic                  store_en;
    logic [XLEN-1:0]       store_data;
  } ex_wb_pipe_t;

  // One register write or forward candidate
  typedef struct packed {
    logic                  we;
    logic [REG_ADDR_W-1:0] waddr;
    logic [XLEN-1:0]       wdata;
  } rf_wr_t;

endpackage

`default_nettype wire

/* hw/core_register_file.sv */
////////////////////////////////////////
// 31 writable registers, x0 reads zero
// Combinational reads, write lands at the clock edge
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module core_register_file (
  input  logic                            clk_i,
  input  logic                            reset_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_a_i,
  input  logic [core_pkg::REG_ADDR_W-1:0] raddr_b_i,
  output logic [core_pkg::XLEN-1:0]       rdata_a_o,
  output logic [core_pkg::XLEN-1:0]       rdata_b_o,
  input  core_pkg::rf_wr_t                wr_i
);

  // x0 has no storage
  logic [core_pkg::XLEN-1:0] regs_q [1:core_pkg::NUM_REGS-1];

  // Write port, x0 writes dropped
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 1; i < core_pkg::NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_i.we && (wr_i.waddr != '0)) begin
      regs_q[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Read ports
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

`default_nettype wire

/* hw/core_wb_stage.sv */
////////////////////////////////////////
// Register write and store port
// Store completes at grant, no response phase
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module core_wb_stage (
  input  core_pkg::ex_wb_pipe_t     ex_wb_pipe_i,
  output logic                      wb_ready_o,
  output logic                      data_req_o,
  output logic [core_pkg::XLEN-1:0] data_addr_o,
  output logic [core_pkg::XLEN-1:0] data_wdata_o,
  input  logic                      data_gnt_i,
  output core_pkg::rf_wr_t          wb_wr_o
);

  logic store_pending;

  ////////////////////////////////////////
  // Store request
  ////////////////////////////////////////

  // EX/WB holds the item, so request and payload stay put until grant
  assign store_pending = ex_wb_pipe_i.valid && ex_wb_pipe_i.store_en;

  assign data_req_o   = store_pending;
  assign data_addr_o  = ex_wb_pipe_i.result;
  assign data_wdata_o = ex_wb_pipe_i.store_data;

  // Only an ungranted store stalls
  assign wb_ready_o = !store_pending || data_gnt_i;

  ////////////////////////////////////////
  // Register write
  ////////////////////////////////////////

  // Also the WB forward into ID
  assign wb_wr_o.we    = ex_wb_pipe_i.valid && ex_wb_pipe_i.rf_we;
  assign wb_wr_o.waddr = ex_wb_pipe_i.rd;
  assign wb_wr_o.wdata = ex_wb_pipe_i.result;

endmodule

`default_nettype wire

/* hw/mini_core.sv */
////////////////////////////////////////
// Four-stage RV32I subset core
// Store-only data bus, one fetch in flight
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mini_core (
  // Clock, reset and control
  input  logic                      clk_i,
  input  logic                      reset_i,
  input  logic                      fetch_enable_i,
  input  logic [core_pkg::XLEN-1:0] boot_addr_i,
  // Instruction bus
  output logic                      instr_req_o,
  output logic [core_pkg::XLEN-1:0] instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  logic [31:0]               instr_rdata_i,
  // Data bus, stores only
  output logic                      data_req_o,
  output logic [core_pkg::XLEN-1:0] data_addr_o,
  output logic [core_pkg::XLEN-1:0] data_wdata_o,
  input  logic                      data_gnt_i
);

  // Pipeline registers
  core_pkg::if_id_pipe_t if_id_pipe;
  core_pkg::id_ex_pipe_t id_ex_pipe;
  core_pkg::ex_wb_pipe_t ex_wb_pipe;

  // Stage readies
  logic id_ready;
  logic ex_ready;
  logic wb_ready;

  // Write and forward paths
  core_pkg::rf_wr_t ex_fwd;
  core_pkg::rf_wr_t wb_wr;

  core_if_stage if_stage_i (
    .clk_i          ( clk_i          ),
    .reset_i        ( reset_i        ),
    .fetch_enable_i ( fetch_enable_i ),
    .boot_addr_i    ( boot_addr_i    ),
    .instr_req_o    ( instr_req_o    ),
    .instr_addr_o   ( instr_addr_o   ),
    .instr_gnt_i    ( instr_gnt_i    ),
    .instr_rvalid_i ( instr_rvalid_i ),
    .instr_rdata_i  ( instr_rdata_i  ),
    .id_ready_i     ( id_ready       ),
    .if_id_pipe_o   ( if_id_pipe     )
  );

  core_id_stage id_stage_i (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .if_id_pipe_i ( if_id_pipe ),
    .id_ready_o   ( id_ready   ),
    .ex_ready_i   ( ex_ready   ),
    .ex_fwd_i     ( ex_fwd     ),
    .wb_wr_i      ( wb_wr      ),
    .id_ex_pipe_o ( id_ex_pipe )
  );

  core_ex_stage ex_stage_i (
    .clk_i        ( clk_i      ),
    .reset_i      ( reset_i    ),
    .id_ex_pipe_i ( id_ex_pipe ),
    .ex_ready_o   ( ex_ready   ),
    .wb_ready_i   ( wb_ready   ),
    .ex_fwd_o     ( ex_fwd     ),
    .ex_wb_pipe_o ( ex_wb_pipe )
  );

  core_wb_stage wb_stage_i (
    .ex_wb_pipe_i ( ex_wb_pipe   ),
    .wb_ready_o   ( wb_ready     ),
    .data_req_o   ( data_req_o   ),
    .data_addr_o  ( data_addr_o  ),
    .data_wdata_o ( data_wdata_o ),
    .data_gnt_i   ( data_gnt_i   ),
    .wb_wr_o      ( wb_wr        )
  );

endmodule

`default_nettype wire

/* mini_core.f */
hw/core_pkg.sv
hw/core_register_file.sv
hw/core_if_stage.sv
hw/core_id_stage.sv
hw/core_ex_stage.sv
hw/core_wb_stage.sv
hw/mini_core.sv
verif/mini_core_assert.sv
verif/mini_core_tb.sv

/* verif/mini_core_assert.sv */
////////////////////////////////////////
// Bus protocol checks for mini_core, bound to every instance
// Sampled on clk_i, quiet during reset
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mini_core_assert (
  input logic        clk_i,
  input logic        reset_i,
  input logic        instr_req_o,
  input logic [31:0] instr_addr_o,
  input logic        instr_gnt_i,
  input logic        instr_rvalid_i,
  input logic        data_req_o,
  input logic [31:0] data_addr_o,
  input logic [31:0] data_wdata_o,
  input logic        data_gnt_i
);

  // Fetch in flight, set at grant and cleared by the response
  logic outstanding_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      outstanding_q <= 1'b0;
    end else if (instr_req_o && instr_gnt_i) begin
      outstanding_q <= 1'b1;
    end else if (instr_rvalid_i) begin
      outstanding_q <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // Request stability until grant
  ////////////////////////////////////////

  a_instr_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o))
    else $error("instruction request dropped or changed before grant");

  a_data_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    data_req_o && !data_gnt_i |=>
      data_req_o && $stable(data_addr_o) && $stable(data_wdata_o))
    else $error("store request dropped or changed before grant");

  // Only one fetch may be open at a time
  a_one_outstanding: assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding_q |-> !instr_req_o)
    else $error("instruction request issued while a response is outstanding");

endmodule

bind mini_core mini_core_assert u_mini_core_assert (.*);

`default_nettype wire

/* verif/mini_core_tb.sv */
////////////////////////////////////////
// Random program against a reference ISS, random bus delays
// Fetches past the program end return NOPs
////////////////////////////////////////
`timescale 1ns/10ps
`default_nettype none

module mini_core_tb;

  localparam int          NPROG    = 160;
  localparam int          NTESTS   = 4;
  localparam int          TIMEOUT  = 20000;
  localparam logic [31:0] BOOT     = 32'h0000_0400;
  localparam logic [31:0] NOP_WORD = 32'h0000_0013;

  logic        clk_i;
  logic        reset_i;
  logic        fetch_enable_i;
  logic [31:0] boot_addr_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        data_req_o;
  logic [31:0] data_addr_o;
  logic [31:0] data_wdata_o;
  logic        data_gnt_i;

  integer      seed;
  logic [31:0] prog [0:NPROG-1];
  logic [31:0] exp_addr_q [$];
  logic [31:0] exp_data_q [$];
  logic [4:0]  recent [0:3];
  int          errors;
  int          test_err [0:NTESTS-1];
  int          fetch_cnt;
  int          store_cnt;
  int          cyc;
  logic        rsp_pending;
  int          rsp_delay;
  logic [31:0] rsp_word;

  mini_core u_mini_core (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Mismatch report, test ids index test_err
  task automatic compare(input string name, input int test_id,
                         input logic [31:0] expected, input logic [31:0] actual);
    if (expected !== actual) begin
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
      errors++;
      test_err[test_id]++;
    end
  endtask

  // Mostly a recent destination, else one of x0..x7
  task automatic pick_reg(output logic [4:0] r_o);
    logic [31:0] r;
    r = $random(seed);
    if (r[0]) begin
      r_o = recent[r[2:1]];
    end else begin
      r_o = {2'b00, r[5:3]};
    end
  endtask

  ////////////////////////////////////////
  // Program and reference ISS
  ////////////////////////////////////////

  task automatic build_program();
    logic [31:0] r;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [2:0]  f3_tab [0:4];
    f3_tab = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
    for (int k = 0; k < 4; k++) recent[k] = 5'(k + 1);
    for (int i = 0; i < NPROG; i++) begin
      r = $random(seed);
      pick_reg(rd);
      pick_reg(rs1);
      pick_reg(rs2);
      f3 = f3_tab[int'(r[10:8]) % 5];
      f7 = (f3 == 3'b000 && r[11]) ? 7'h20 : 7'h00;
      if (r[3:0] < 4'd4) begin
        prog[i] = {r[31:20], rs1, f3, rd, 7'b0010011};
      end else if (r[3:0] < 4'd7) begin
        prog[i] = {f7, rs2, rs1, f3, rd, 7'b0110011};
      end else if (r[3:0] < 4'd9) begin
        prog[i] = {r[31:12], rd, 7'b0110111};
      end else if (r[3:0] < 4'd14) begin
        prog[i] = {r[31:25], rs2, rs1, 3'b010, r[11:7], 7'b0100011};
      end else if (r[12]) begin
        // Shift immediate, not part of this subset
        prog[i] = {r[31:20], rs1, 3'b001, rd, 7'b0010011};
      end else begin
        prog[i] = {r[31:7], 7'b0001011};
      end
      if (r[3:0] < 4'd9) begin
        recent[r[14:13]] = rd;
      end
    end
  endtask

  task automatic run_iss();
    logic [31:0] regs [0:31];
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] val;
    logic        we;
    for (int k = 0; k < 32; k++) regs[k] = '0;
    for (int i = 0; i < NPROG; i++) begin
      w   = prog[i];
      a   = regs[w[19:15]];
      b   = regs[w[24:20]];
      we  = 1'b0;
      val = '0;
      if (w[6:0] == 7'b0010011) begin
        b  = {{20{w[31]}}, w[31:20]};
        we = 1'b1;
        case (w[14:12])
          3'b000:  val = a + b;
          3'b010:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b100:  val = a ^ b;
          3'b110:  val = a | b;
          3'b111:  val = a & b;
          default: we = 1'b0;
        endcase
      end else if (w[6:0] == 7'b0110011) begin
        we = 1'b1;
        case ({w[31:25], w[14:12]})
          10'b0000000_000: val = a + b;
          10'b0100000_000: val = a - b;
          10'b0000000_010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          10'b0000000_100: val = a ^ b;
          10'b0000000_110: val = a | b;
          10'b0000000_111: val = a & b;
          default:         we = 1'b0;
        endcase
      end else if (w[6:0] == 7'b0110111) begin
        we  = 1'b1;
        val = {w[31:12], 12'h000};
      end else if (w[6:0] == 7'b0100011 && w[14:12] == 3'b010) begin
        exp_addr_q.push_back(a + {{20{w[31]}}, w[31:25], w[11:7]});
        exp_data_q.push_back(b);
      end
      if (we && w[11:7] != 5'd0) regs[w[11:7]] = val;
    end
  endtask

  ////////////////////////////////////////
  // Bus models and monitors
  ////////////////////////////////////////

  always @(posedge clk_i) begin : bus_models
    logic [31:0] r;
    r = $random(seed);
    cyc++;
    instr_gnt_i    <= r[0] | r[1];
    data_gnt_i     <= r[2];
    instr_rvalid_i <= 1'b0;
    if (cyc > 1 && (reset_i || !fetch_enable_i)) begin
      compare("reset_enable requests", 0, 32'd0, {30'd0, instr_req_o, data_req_o});
    end
    if (reset_i) begin
      rsp_pending = 1'b0;
    end else begin
      // Pending response goes out after its delay
      if (rsp_pending) begin
        if (rsp_delay == 0) begin
          instr_rvalid_i <= 1'b1;
          instr_rdata_i  <= rsp_word;
          rsp_pending = 1'b0;
        end else begin
          rsp_delay--;
        end
      end
      if (instr_req_o && instr_gnt_i) begin
        if (rsp_pending) begin
          $display("Instruction grant accepted while a response was still pending");
          errors++;
          test_err[1]++;
        end
        if (fetch_cnt == 0) begin
          compare("reset_enable first fetch", 0, BOOT, instr_addr_o);
        end else begin
          compare("sequential_fetch", 1, BOOT + 32'(fetch_cnt * 4), instr_addr_o);
        end
        rsp_word    = (fetch_cnt < NPROG) ? prog[fetch_cnt] : NOP_WORD;
        rsp_delay   = int'(r[6:5]);
        rsp_pending = 1'b1;
        fetch_cnt++;
      end
      if (data_req_o && data_gnt_i) begin
        if (exp_addr_q.size() == 0) begin
          $display("Store to %h seen after the last expected store", data_addr_o);
          errors++;
          test_err[2]++;
        end else begin
          compare("store_stream address", 2, exp_addr_q.pop_front(), data_addr_o);
          compare("store_stream data", 2, exp_data_q.pop_front(), data_wdata_o);
        end
        store_cnt++;
      end
    end
  end

  ////////////////////////////////////////
  // Sequence and report
  ////////////////////////////////////////

  initial begin : main
    int   exp_stores;
    int   wait_cyc;
    int   failed;
    logic timed_out;
    seed           = 32'hf547;
    reset_i        = 1'b1;
    fetch_enable_i = 1'b0;
    boot_addr_i    = BOOT;
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_rdata_i  = '0;
    data_gnt_i     = 1'b0;
    errors         = 0;
    fetch_cnt      = 0;
    store_cnt      = 0;
    cyc            = 0;
    rsp_pending    = 1'b0;
    timed_out      = 1'b0;
    failed         = 0;
    for (int t = 0; t < NTESTS; t++) test_err[t] = 0;
    build_program();
    run_iss();
    exp_stores = exp_addr_q.size();

    repeat (3) @(posedge clk_i);
    reset_i <= 1'b0;
    repeat (5) @(posedge clk_i);
    fetch_enable_i <= 1'b1;

    wait_cyc = 0;
    while (fetch_cnt == 0 && wait_cyc < TIMEOUT) begin
      @(posedge clk_i);
      wait_cyc++;
    end
    if (fetch_cnt == 0) begin
      $display("Timeout: no instruction fetch after fetch enable");
      timed_out = 1'b1;
    end
    $display("Test reset_enable finished, %0d errors", test_err[0]);

    wait_cyc = 0;
    while (!timed_out && store_cnt < exp_stores && wait_cyc < TIMEOUT) begin
      @(posedge clk_i);
      wait_cyc++;
    end
    if (!timed_out && store_cnt < exp_stores) begin
      $display("Timeout: only %0d of %0d stores seen", store_cnt, exp_stores);
      timed_out = 1'b1;
    end
    // Room for any stray extra store
    repeat (40) @(posedge clk_i);
    $display("Test sequential_fetch finished, %0d errors", test_err[1]);
    $display("Test store_stream finished, %0d errors", test_err[2]);
    compare("store_count", 3, 32'(exp_stores), 32'(store_cnt));
    $display("Test store_count finished, %0d errors", test_err[3]);

    for (int t = 0; t < NTESTS; t++) begin
      if (test_err[t] != 0) failed++;
    end
    $display("Tests run %0d, failed %0d, errors %0d, stores %0d", NTESTS, failed,
             errors, store_cnt);
    if (errors == 0 && !timed_out) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire
